//--- files.f
logic/div_pkg.sv
logic/div_ctrl.sv
logic/div_datapath.sv
logic/div_smallnum.sv
logic/div_result.sv
logic/div_top.sv
tests/div_checker.sv
tests/div_tb.sv

//--- Bender.yml
package:
  name: div_seq

sources:
  - logic/div_pkg.sv
  - logic/div_ctrl.sv
  - logic/div_datapath.sv
  - logic/div_smallnum.sv
  - logic/div_result.sv
  - logic/div_top.sv
  - target: test
    files:
      - tests/div_checker.sv
      - tests/div_tb.sv

//--- tests/div_tb.sv
// Testbench for the sequential divider
// Directed corner cases, LFSR random divides and flushes; the bound checker judges results
`timescale 1ns/1ns
`default_nettype none

module div_tb;

  localparam int unsigned XLEN    = div_pkg::XLEN;
  localparam int unsigned SMALL_W = 4;
  localparam int unsigned TIMEOUT = XLEN + 8;    // Cycles allowed for one divide
  localparam logic [31:0] POLY    = 32'h8020_0003;
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN - 1){1'b0}}};

  logic              clk;
  logic              rst_n;
  logic              start;
  div_pkg::div_req_t req;
  logic              flush;
  logic              fast_div_disable;
  logic              busy;
  logic              finish;
  logic              finish_early;
  logic [XLEN-1:0]   result;

  logic [31:0] lfsr_state;
  int unsigned timeouts;

  div_top #(.SMALL_W(SMALL_W)) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .req              (req),
    .flush            (flush),
    .fast_div_disable (fast_div_disable),
    .busy             (busy),
    .finish           (finish),
    .finish_early     (finish_early),
    .result           (result)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? POLY : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return val;
  endfunction

  function automatic logic [XLEN-1:0] gen_operand();
    logic [2:0] sel;
    sel = 3'(rand_bits(3));
    case (sel)
      3'd0, 3'd1: return XLEN'(rand_bits(SMALL_W));   // Shortcut range
      3'd2:       return '0;
      3'd3:       return '1;
      3'd4:       return MOST_NEG;
      default:    return rand_bits(XLEN);
    endcase
  endfunction

  // Called at the drive point, returns at the drive point after busy has dropped
  task automatic run_divide(input logic [XLEN-1:0] dividend, input logic [XLEN-1:0] divisor,
                            input logic is_signed, input logic want_rem, input logic no_fast);
    int unsigned waited;
    logic        done;
    req.dividend     = dividend;
    req.divisor      = divisor;
    req.is_signed    = is_signed;
    req.want_rem     = want_rem;
    fast_div_disable = no_fast;
    start            = 1'b1;
    @(posedge clk);
    #1;
    start  = 1'b0;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < TIMEOUT) begin
      @(negedge clk);         // finish is stable mid-cycle
      done = finish;
      waited++;
    end
    if (!done) begin
      timeouts++;
      $display("Timeout: divide of %h by %h never finished", dividend, divisor);
      @(posedge clk);
      #1;
      flush = 1'b1;           // Recover the DUT
      @(posedge clk);
      #1;
      flush = 1'b0;
    end
    @(posedge clk);
    #1;
  endtask

  // Flush lands after `delay` further cycles, well before any normal finish
  task automatic run_flush(input int unsigned delay);
    req.dividend     = rand_bits(XLEN);
    req.divisor      = gen_operand();
    req.is_signed    = 1'(rand_bits(1));
    req.want_rem     = 1'(rand_bits(1));
    fast_div_disable = 1'b1;
    start            = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    repeat (delay) @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  initial begin
    clk              = 1'b0;
    rst_n            = 1'b0;
    start            = 1'b0;
    req              = '0;
    flush            = 1'b0;
    fast_div_disable = 1'b0;
    timeouts         = 0;
    lfsr_state       = 32'h8679_e71b;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (5) @(posedge clk);   // Idle, no finish expected
    #1;

    // Divide by zero and signed overflow
    run_divide(32'h1234_5678, 32'h0, 1'b0, 1'b0, 1'b0);
    run_divide(32'h1234_5678, 32'h0, 1'b0, 1'b1, 1'b0);
    run_divide(32'h8765_4321, 32'h0, 1'b1, 1'b0, 1'b0);
    run_divide(32'h8765_4321, 32'h0, 1'b1, 1'b1, 1'b0);
    run_divide(MOST_NEG, '1, 1'b1, 1'b0, 1'b0);
    run_divide(MOST_NEG, '1, 1'b1, 1'b1, 1'b0);
    run_divide(MOST_NEG, '1, 1'b0, 1'b0, 1'b0);

    // Shortcut and its exclusions
    run_divide(32'd13, 32'd3, 1'b0, 1'b0, 1'b0);
    run_divide(32'd13, 32'd3, 1'b0, 1'b1, 1'b0);
    run_divide(32'd13, 32'd3, 1'b0, 1'b0, 1'b1);
    run_divide(32'd15, 32'd0, 1'b0, 1'b0, 1'b0);
    run_divide(32'd5, 32'd7, 1'b1, 1'b0, 1'b0);
    run_divide(-32'sd7, 32'd2, 1'b1, 1'b0, 1'b0);
    run_divide(32'd16, 32'd2, 1'b0, 1'b0, 1'b0);

    for (int i = 0; i < 150; i++) begin
      run_divide(gen_operand(), gen_operand(), 1'(rand_bits(1)), 1'(rand_bits(1)),
                 rand_bits(2) == 0);
    end

    // Each flush is followed by a request that must complete
    for (int i = 0; i < 8; i++) begin
      run_flush(1 + rand_bits(4));
      run_divide(gen_operand(), gen_operand(), 1'(rand_bits(1)), 1'(rand_bits(1)), 1'b0);
    end

    repeat (3) @(posedge clk);
    $display("Errors: %0d assertion failures, %0d timeouts", u_dut.u_checker.fail_count,
             timeouts);
    if (u_dut.u_checker.fail_count == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/div_checker.sv
// Divider checker, bound into the top level
// Reference model for quotient and remainder plus protocol and latency assertions
`timescale 1ns/1ns
`default_nettype none

module div_checker #(
  parameter int unsigned SMALL_W = 4
) (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     start,
  input div_pkg::div_req_t        req,
  input logic                     flush,
  input logic                     fast_div_disable,
  input logic                     busy,
  input logic                     finish,
  input logic                     finish_early,
  input logic [div_pkg::XLEN-1:0] result
);

  localparam int unsigned N = div_pkg::XLEN;
  localparam logic [N-1:0] MOST_NEG = {1'b1, {(N - 1){1'b0}}};

  logic [N-1:0] exp_result;
  logic         exp_hit;      // Shortcut expected for this request
  int unsigned  exp_lat;
  int unsigned  cyc;          // Edges since the start edge
  logic         pending;      // Request started, not yet finished or flushed
  int unsigned  fail_count = 0;

  // RISC-V divide rules, rounding toward zero
  function automatic logic [N-1:0] ref_divide(input div_pkg::div_req_t r);
    logic signed [N-1:0] sa;
    logic signed [N-1:0] sb;
    sa = r.dividend;
    sb = r.divisor;
    if (r.divisor == '0) begin
      return r.want_rem ? r.dividend : '1;
    end
    if (r.is_signed && r.dividend == MOST_NEG && r.divisor == '1) begin
      return r.want_rem ? '0 : MOST_NEG;   // Signed overflow
    end
    if (r.is_signed) begin
      return r.want_rem ? sa % sb : sa / sb;
    end
    return r.want_rem ? r.dividend % r.divisor : r.dividend / r.divisor;
  endfunction

  function automatic logic ref_hit(input div_pkg::div_req_t r, input logic no_fast);
    return !r.want_rem && !no_fast && (r.divisor != '0) &&
           (r.dividend < (64'd1 << SMALL_W)) && (r.divisor < (64'd1 << SMALL_W));
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_result <= '0;
      exp_hit    <= 1'b0;
      exp_lat    <= 0;
      cyc        <= 0;
      pending    <= 1'b0;
    end else if (start) begin
      exp_result <= ref_divide(req);
      exp_hit    <= ref_hit(req, fast_div_disable);
      if (ref_hit(req, fast_div_disable)) begin
        exp_lat <= 1;
      end else begin
        exp_lat <= req.want_rem ? N + 2 : N + 1;
      end
      cyc     <= 1;
      pending <= 1'b1;
    end else begin
      if (finish || flush) begin
        pending <= 1'b0;
      end
      if (pending) begin
        cyc <= cyc + 1;
      end
    end
  end

  a_result: assert property (@(posedge clk) disable iff (!rst_n) finish |-> result == exp_result)
    else begin
      fail_count++;
      $error("[ERROR] %0t result: got %h, expected %h", $time, $sampled(result),
             $sampled(exp_result));
    end

  a_latency: assert property (@(posedge clk) disable iff (!rst_n) finish |-> cyc == exp_lat)
    else begin
      fail_count++;
      $error("[ERROR] %0t finish latency: got %0d, expected %0d", $time, $sampled(cyc),
             $sampled(exp_lat));
    end

  a_early: assert property (@(posedge clk) disable iff (!rst_n)
                            finish |-> finish_early == exp_hit)
    else begin
      fail_count++;
      $error("[ERROR] %0t finish_early: got %b, expected %b", $time, $sampled(finish_early),
             $sampled(exp_hit));
    end

  a_early_alone: assert property (@(posedge clk) disable iff (!rst_n) finish_early |-> finish)
    else begin
      fail_count++;
      $error("finish_early pulsed without finish at %0t", $time);
    end

  // Also catches a finish for a flushed request
  a_no_request: assert property (@(posedge clk) disable iff (!rst_n) finish |-> pending)
    else begin
      fail_count++;
      $error("finish pulsed with no request outstanding at %0t", $time);
    end

  a_busy_run: assert property (@(posedge clk) disable iff (!rst_n) pending |-> busy)
    else begin
      fail_count++;
      $error("busy dropped before the request finished at %0t", $time);
    end

  a_run_end: assert property (@(posedge clk) disable iff (!rst_n)
                              (finish || flush) |=> !busy)
    else begin
      fail_count++;
      $error("busy still high one edge after finish or flush at %0t", $time);
    end

  a_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |-> !finish)
    else begin
      fail_count++;
      $error("finish was not suppressed by flush at %0t", $time);
    end

  // First edge after reset release
  a_reset: assert property (@(posedge clk)
                            $rose(rst_n) |-> !busy && !finish && !finish_early)
    else begin
      fail_count++;
      $error("busy, finish or finish_early high right after reset at %0t", $time);
    end

endmodule

bind div_top div_checker #(.SMALL_W(SMALL_W)) u_checker (
  .clk              (clk),
  .rst_n            (rst_n),
  .start            (start),
  .req              (req),
  .flush            (flush),
  .fast_div_disable (fast_div_disable),
  .busy             (busy),
  .finish           (finish),
  .finish_early     (finish_early),
  .result           (result)
);

`default_nettype wire

//--- logic/div_top.sv
// Sequential integer divider, top level
// Non-restoring divide at one bit per cycle with a one-cycle small-operand shortcut
`timescale 1ns/1ns
`default_nettype none

module div_top #(
  parameter int unsigned SMALL_W = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  div_pkg::div_req_t        req,
  input  logic                     flush,
  input  logic                     fast_div_disable,
  output logic                     busy,
  output logic                     finish,
  output logic                     finish_early,
  output logic [div_pkg::XLEN-1:0] result
);

  div_pkg::div_mode_t       mode;
  div_pkg::div_raw_t        raw;
  logic                     first_cycle;
  logic                     step;
  logic                     correct_phase;
  logic                     shortcut_win;
  logic                     small_hit;
  logic [SMALL_W-1:0]       small_q;
  logic [div_pkg::XLEN-1:0] q_low;
  logic [div_pkg::XLEN-1:0] m_low;

  div_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .req              (req),
    .flush            (flush),
    .fast_div_disable (fast_div_disable),
    .small_hit        (small_hit),
    .mode             (mode),
    .first_cycle      (first_cycle),
    .step             (step),
    .correct_phase    (correct_phase),
    .shortcut_win     (shortcut_win),
    .busy             (busy),
    .finish           (finish),
    .finish_early     (finish_early)
  );

  div_datapath u_datapath (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .req           (req),
    .mode          (mode),
    .first_cycle   (first_cycle),
    .step          (step),
    .correct_phase (correct_phase),
    .raw           (raw),
    .q_low         (q_low),
    .m_low         (m_low)
  );

  div_smallnum #(.SMALL_W(SMALL_W)) u_smallnum (
    .q_low        (q_low),
    .m_low        (m_low),
    .shortcut_win (shortcut_win),
    .small_hit    (small_hit),
    .small_q      (small_q)
  );

  div_result #(.SMALL_W(SMALL_W)) u_result (
    .raw       (raw),
    .mode      (mode),
    .small_hit (small_hit),
    .small_q   (small_q),
    .result    (result)
  );

endmodule

`default_nettype wire

//--- logic/div_result.sv
// Divider result stage
// Applies the sign fix-up and picks quotient, remainder or the short quotient
`timescale 1ns/1ns
`default_nettype none

module div_result #(
  parameter int unsigned SMALL_W = 4
) (
  input  div_pkg::div_raw_t        raw,
  input  div_pkg::div_mode_t       mode,
  input  logic                     small_hit,
  input  logic [SMALL_W-1:0]       small_q,
  output logic [div_pkg::XLEN-1:0] result
);

  localparam int unsigned N = div_pkg::XLEN;

  logic         quot_neg;
  logic         rem_neg;
  logic [N-1:0] quot_fix;
  logic [N-1:0] rem_fix;
  logic [N-1:0] small_ext;

  // Quotient negative when operand signs differ
  assign quot_neg = mode.signed_eff & (mode.dividend_neg ^ mode.divisor_neg);
  // Remainder follows the dividend sign
  assign rem_neg  = mode.signed_eff & mode.dividend_neg;

  assign quot_fix = quot_neg ? (~raw.quot + 1'b1) : raw.quot;
  assign rem_fix  = rem_neg ? (~raw.rem + 1'b1) : raw.rem;

  assign small_ext = {{(N - SMALL_W){1'b0}}, small_q};

  always_comb begin
    if (small_hit) begin
      result = small_ext;
    end else if (mode.want_rem) begin
      result = rem_fix;
    end else begin
      result = quot_fix;
    end
  end

endmodule

`default_nettype wire

//--- logic/div_smallnum.sv
// Small-operand shortcut for the divider
// Detects operands that fit in SMALL_W bits and divides them in one cycle
`timescale 1ns/1ns
`default_nettype none

module div_smallnum #(
  parameter int unsigned SMALL_W = 4
) (
  input  logic [div_pkg::XLEN-1:0] q_low,
  input  logic [div_pkg::XLEN-1:0] m_low,
  input  logic                     shortcut_win,
  output logic                     small_hit,
  output logic [SMALL_W-1:0]       small_q
);

  localparam int unsigned N = div_pkg::XLEN;

  logic               q_fits;
  logic               m_fits;
  logic               m_nonzero;
  logic [SMALL_W-1:0] n_small;
  logic [SMALL_W-1:0] d_small;
  logic [SMALL_W:0]   rem_acc;

  // Upper bits all zero, so negative signed operands never hit
  assign q_fits    = (q_low[N-1:SMALL_W] == '0);
  assign m_fits    = (m_low[N-1:SMALL_W] == '0);
  assign m_nonzero = (m_low != '0);

  assign small_hit = shortcut_win & q_fits & m_fits & m_nonzero;

  assign n_small = q_low[SMALL_W-1:0];
  assign d_small = m_low[SMALL_W-1:0];

  // Restoring array divide, one row per quotient bit
  always_comb begin
    rem_acc = '0;
    small_q = '0;
    for (int i = SMALL_W - 1; i >= 0; i--) begin
      rem_acc = {rem_acc[SMALL_W-1:0], n_small[i]};
      if (rem_acc >= {1'b0, d_small}) begin
        rem_acc    = rem_acc - {1'b0, d_small};
        small_q[i] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/div_datapath.sv
// Non-restoring divide datapath with A, Q and M registers
// Negates a signed negative dividend on entry and restores a negative remainder once
`timescale 1ns/1ns
`default_nettype none

module div_datapath (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  div_pkg::div_req_t        req,
  input  div_pkg::div_mode_t       mode,
  input  logic                     first_cycle,
  input  logic                     step,
  input  logic                     correct_phase,
  output div_pkg::div_raw_t        raw,
  output logic [div_pkg::XLEN-1:0] q_low,
  output logic [div_pkg::XLEN-1:0] m_low
);

  localparam int unsigned N = div_pkg::XLEN;

  logic [N:0]   a_q;        // Partial remainder, one extra sign bit
  logic [N-1:0] q_q;        // Dividend shifting out, quotient shifting in
  logic [N:0]   m_q;        // Divisor, sign extended when signed

  logic [N-1:0] q_eff;
  logic [N:0]   a_src;
  logic [N:0]   m_eff;
  logic [N:0]   a_next;
  logic         neg_entry;
  logic         m_comp;
  logic         add_op;
  logic         fix_a;
  logic         a_en;

  // Dividend magnitude is formed in the first step itself
  assign neg_entry = first_cycle & mode.signed_eff & mode.dividend_neg;
  assign q_eff     = neg_entry ? (~q_q + 1'b1) : q_q;

  // M already negative, so add and subtract trade places
  assign m_comp = mode.signed_eff & mode.divisor_neg;
  assign add_op = a_q[N] ^ m_comp;

  assign fix_a = correct_phase & a_q[N];
  assign a_en  = step | fix_a;

  // Correction adds the divisor back without a shift
  assign a_src  = correct_phase ? a_q : {a_q[N-1:0], q_eff[N-1]};
  assign m_eff  = add_op ? m_q : ~m_q;
  assign a_next = a_src + m_eff + {{N{1'b0}}, ~add_op};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
      q_q <= '0;
      m_q <= '0;
    end else if (start) begin
      a_q <= '0;
      q_q <= req.dividend;
      m_q <= {req.is_signed & req.divisor[N-1], req.divisor};
    end else begin
      if (a_en) begin
        a_q <= a_next;
      end
      if (step) begin
        q_q <= {q_eff[N-2:0], ~a_next[N]};  // Quotient bit is the inverted new sign
      end
    end
  end

  assign raw.quot = q_q;
  assign raw.rem  = a_q[N-1:0];   // Nonnegative once corrected

  // Held operands for the shortcut, raw until the first step
  assign q_low = q_q;
  assign m_low = m_q[N-1:0];

endmodule

`default_nettype wire

//--- logic/div_ctrl.sv
// Divider control: run state, iteration count and finish generation
// Captures the mode flags on start and ends the run on shortcut, count limit or flush
`timescale 1ns/1ns
`default_nettype none

module div_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  div_pkg::div_req_t  req,
  input  logic               flush,
  input  logic               fast_div_disable,
  input  logic               small_hit,
  output div_pkg::div_mode_t mode,
  output logic               first_cycle,
  output logic               step,
  output logic               correct_phase,
  output logic               shortcut_win,
  output logic               busy,
  output logic               finish,
  output logic               finish_early
);

  localparam int unsigned CNT_W = div_pkg::CNT_W;

  // Count is 1 in the first cycle, so it equals the cycle number after start
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(div_pkg::XLEN);
  localparam logic [CNT_W-1:0] QUOT_DONE = CNT_W'(div_pkg::XLEN + 1);
  localparam logic [CNT_W-1:0] REM_DONE  = CNT_W'(div_pkg::XLEN + 2);

  logic [CNT_W-1:0] count;
  logic             small_hold;   // Last run ended on a shortcut hit
  logic             limit_hit;

  // Kept open after a hit so the short quotient stays on the result
  assign shortcut_win  = (first_cycle & ~mode.want_rem & ~fast_div_disable) | small_hold;

  assign limit_hit     = mode.want_rem ? (count == REM_DONE) : (count == QUOT_DONE);
  assign finish        = busy & ~flush & (small_hit | limit_hit);
  assign finish_early  = busy & ~flush & small_hit;

  // A hit freezes Q and M, the shortcut reads them
  assign step          = busy & ~small_hit & (count <= LAST_STEP);
  assign correct_phase = busy & mode.want_rem & (count == QUOT_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      first_cycle <= 1'b0;
      count       <= '0;
      small_hold  <= 1'b0;
      mode        <= '0;
    end else begin
      first_cycle <= start;
      if (start) begin
        busy              <= 1'b1;
        count             <= CNT_W'(1);
        small_hold        <= 1'b0;
        mode.signed_eff   <= req.is_signed & (req.divisor != '0);
        mode.want_rem     <= req.want_rem;
        mode.dividend_neg <= req.is_signed & req.dividend[div_pkg::XLEN-1];
        mode.divisor_neg  <= req.is_signed & req.divisor[div_pkg::XLEN-1];
      end else begin
        if (finish || flush) begin
          busy <= 1'b0;                 // Falls on the edge after finish
        end else if (busy) begin
          count <= count + 1'b1;
        end
        if (finish_early) begin
          small_hold <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/div_pkg.sv
// Shared widths and packed types for the sequential integer divider
// Request, captured mode flags and the raw quotient/remainder pair
`default_nettype none

package div_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Iteration counter, must reach XLEN+2 for the remainder path
  localparam int unsigned CNT_W = 6;

  // One divide request, sampled on start
  typedef struct packed {
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    logic            is_signed;   // Signed divide or remainder
    logic            want_rem;    // Remainder instead of quotient
  } div_req_t;

  // Flags captured at start and held for the whole run
  typedef struct packed {
    logic signed_eff;     // Signed and divisor nonzero
    logic want_rem;
    logic dividend_neg;   // Dividend sign, signed only
    logic divisor_neg;    // Divisor sign, signed only
  } div_mode_t;

  // Unsigned result as held in the Q and A registers
  typedef struct packed {
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;
  } div_raw_t;

endpackage

`default_nettype wire
